// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_up_busif -f up_busif_top.f &&
./obj_dir/Vtb_up_busif | tee /dev/stderr | grep "Test completed successfully" > /dev/null ||
{ echo "simulation did not pass"; exit 1; }

// ==== tb_up_busif.sv ====
`default_nettype none

module tb_up_busif;
  import up_pkg::*;

  localparam int            ACK_TIMEOUT = 64;
  localparam up_byte_addr_t A_VER   = 32'h0000_0000;
  localparam up_byte_addr_t A_ID    = 32'h0000_0004;
  localparam up_byte_addr_t A_SCR   = 32'h0000_0008;
  localparam up_byte_addr_t A_USER  = 32'h0000_0040;  // Block 1
  localparam up_byte_addr_t A_UNMAP = 32'h0000_0148;  // Block 5, nobody answers

  typedef struct {
    string         name;
    logic          wr;
    up_byte_addr_t addr;
    logic          use_lfsr;
    up_data_t      wdata;
    logic          from_write;  // Expect the last data written to addr
    up_data_t      exp_data;
    int            hold;        // Extra cycles select stays high after the ack
    logic          chk_lat;
  } entry_t;

  logic          up_clk = 1'b0;
  logic          up_rstn;
  logic          upif_sel;
  logic          upif_rwn;
  up_byte_addr_t upif_addr;
  up_data_t      upif_wdata;
  logic          upif_wack;
  logic          upif_rack;
  up_data_t      upif_rdata;

  logic [31:0] lfsr_state = 32'he895_2b8f;
  entry_t      table_q[$];
  up_data_t    written [up_byte_addr_t];
  int          errors = 0;
  int          tests = 0;
  logic        timed_out = 1'b0;

  up_busif_top DUT (.*);

  always #4 up_clk = ~up_clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_word(output up_data_t w);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  task automatic check_data(input string name, input up_data_t exp, input up_data_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error: %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_ack(input string name, input logic exp_w, input logic exp_r,
                           input logic act_w, input logic act_r);
    if ({act_w, act_r} !== {exp_w, exp_r}) begin
      errors++;
      $display("** Error: %s: expected wack/rack %b%b, actual %b%b",
               name, exp_w, exp_r, act_w, act_r);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("** Error: %s: expected latency %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic apply(input entry_t e);
    up_data_t wdata;
    int       lat;
    int       err_before;
    logic     got;
    err_before = errors;
    lat = 0;
    got = 1'b0;
    wdata = e.wdata;
    if (e.use_lfsr) random_word(wdata);
    if (e.wr) written[e.addr] = wdata;
    upif_sel   = 1'b1;
    upif_rwn   = !e.wr;
    upif_addr  = e.addr;
    upif_wdata = wdata;
    while (!got && lat < ACK_TIMEOUT) begin
      @(posedge up_clk);
      #1;
      lat++;
      got = upif_wack | upif_rack;
    end
    tests++;
    if (!got) begin
      errors++;
      timed_out = 1'b1;
      $display("%s: no acknowledge after %0d cycles", e.name, ACK_TIMEOUT);
    end else begin
      check_ack(e.name, e.wr, !e.wr, upif_wack, upif_rack);
      if (!e.wr) check_data(e.name, e.from_write ? written[e.addr] : e.exp_data, upif_rdata);
      if (e.chk_lat) check_latency(e.name, 3, lat);
      for (int i = 0; i < e.hold; i++) begin
        @(posedge up_clk);
        #1;
        check_ack(e.name, 1'b0, 1'b0, upif_wack, upif_rack);  // No second ack while held
      end
      upif_sel = 1'b0;
      @(posedge up_clk);
      #1;
      $display("%s %s", (errors == err_before) ? "PASS" : "FAIL", e.name);
    end
  endtask

  initial begin
    up_rstn    = 1'b0;
    upif_sel   = 1'b0;
    upif_rwn   = 1'b1;
    upif_addr  = '0;
    upif_wdata = '0;

    table_q.push_back(entry_t'{"ver_reset", 1'b0, A_VER, 1'b0, 32'h0, 1'b0,
                               32'h0004_0061, 0, 1'b1});
    table_q.push_back(entry_t'{"id_reset", 1'b0, A_ID, 1'b0, 32'h0, 1'b0, 32'h0, 0, 1'b1});
    table_q.push_back(entry_t'{"scr_reset", 1'b0, A_SCR, 1'b0, 32'h0, 1'b0, 32'h0, 0, 1'b1});
    table_q.push_back(entry_t'{"scr_wr", 1'b1, A_SCR, 1'b1, 32'h0, 1'b0, 32'h0, 0, 1'b1});
    table_q.push_back(entry_t'{"scr_rd", 1'b0, A_SCR, 1'b0, 32'h0, 1'b1, 32'h0, 0, 1'b1});
    table_q.push_back(entry_t'{"ver_wr", 1'b1, A_VER, 1'b0, 32'h1234_5678, 1'b0, 32'h0,
                               0, 1'b0});
    table_q.push_back(entry_t'{"ver_rd", 1'b0, A_VER, 1'b0, 32'h0, 1'b0, 32'h0004_0061,
                               0, 1'b0});
    for (int i = 0; i < 8; i++) begin
      table_q.push_back(entry_t'{$sformatf("user_wr_%0d", i), 1'b1, A_USER + 32'(4 * i),
                                 1'b1, 32'h0, 1'b0, 32'h0, 0, 1'b0});
    end
    for (int i = 0; i < 8; i++) begin
      table_q.push_back(entry_t'{$sformatf("user_rd_%0d", i), 1'b0, A_USER + 32'(4 * i),
                                 1'b0, 32'h0, 1'b1, 32'h0, 0, 1'b0});
    end
    for (int i = 8; i < 16; i++) begin
      table_q.push_back(entry_t'{$sformatf("user_rd_%0d", i), 1'b0, A_USER + 32'(4 * i),
                                 1'b0, 32'h0, 1'b0, 32'h0, 0, 1'b0});
    end
    table_q.push_back(entry_t'{"unmap_rd", 1'b0, A_UNMAP, 1'b0, 32'h0, 1'b0, 32'hdead_dead,
                               0, 1'b0});
    table_q.push_back(entry_t'{"unmap_wr", 1'b1, A_UNMAP, 1'b1, 32'h0, 1'b0, 32'h0, 0, 1'b0});
    table_q.push_back(entry_t'{"scr_after_unmap", 1'b0, A_SCR, 1'b0, 32'h0, 1'b1, 32'h0,
                               0, 1'b0});
    table_q.push_back(entry_t'{"held_scr_rd", 1'b0, A_SCR, 1'b0, 32'h0, 1'b1, 32'h0, 3, 1'b1});
    table_q.push_back(entry_t'{"held_user_wr", 1'b1, A_USER + 32'h8, 1'b1, 32'h0, 1'b0, 32'h0,
                               3, 1'b0});
    table_q.push_back(entry_t'{"user_rd_after_hold", 1'b0, A_USER + 32'h8, 1'b0, 32'h0, 1'b1,
                               32'h0, 0, 1'b0});

    repeat (4) @(posedge up_clk);
    #1 up_rstn = 1'b1;
    foreach (table_q[i]) begin
      if (!timed_out) apply(table_q[i]);  // A stuck bus ends the sequence
    end

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== up_access_fsm.sv ====
`default_nettype none

module up_access_fsm (
  input  logic                  up_clk,
  input  logic                  up_rstn,
  input  logic                  upif_sel,
  input  logic                  upif_rwn,
  input  up_pkg::up_byte_addr_t upif_addr,
  input  up_pkg::up_data_t      upif_wdata,
  output logic                  upif_wack,
  output logic                  upif_rack,
  output up_pkg::up_data_t      upif_rdata,
  up_bus_if.master              bus,
  output logic                  timer_run,
  input  logic                  timer_expired
);
  import up_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STROBE,
    ST_WAIT,
    ST_RELEASE
  } state_t;

  state_t state;
  logic   done;

  assign done      = bus.ack | timer_expired;
  assign timer_run = (state == ST_WAIT);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state      <= ST_IDLE;
      bus.sel    <= 1'b0;
      bus.wr     <= 1'b0;
      bus.addr   <= '0;
      bus.wdata  <= '0;
      upif_wack  <= 1'b0;
      upif_rack  <= 1'b0;
      upif_rdata <= '0;
    end else begin
      bus.sel    <= 1'b0;  // Strobe lasts a single cycle
      upif_wack  <= 1'b0;
      upif_rack  <= 1'b0;
      upif_rdata <= '0;
      case (state)
        ST_IDLE: begin
          if (upif_sel) begin
            bus.sel   <= 1'b1;
            bus.wr    <= ~upif_rwn;
            bus.addr  <= upif_addr[15:2];
            bus.wdata <= upif_wdata;
            state     <= ST_STROBE;
          end
        end
        ST_STROBE: begin
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          if (done) begin
            upif_wack <= bus.wr;
            upif_rack <= ~bus.wr;
            if (!bus.wr) begin
              upif_rdata <= bus.ack ? bus.rdata : TIMEOUT_DATA;
            end
            state <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          if (!upif_sel) state <= ST_IDLE;  // Host must drop select first
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== up_access_timer.sv ====
`default_nettype none

module up_access_timer #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic up_clk,
  input  logic up_rstn,
  input  logic run,
  output logic expired
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      count   <= '0;
      expired <= 1'b0;
    end else if (!run) begin
      count   <= '0;  // Restart for the next access
      expired <= 1'b0;
    end else begin
      if (count != CNT_W'(TIMEOUT_CYCLES)) begin
        count <= count + 1'b1;  // Saturates at the limit
      end
      // Fires once, on the step that brings count to the limit
      expired <= (count == CNT_W'(TIMEOUT_CYCLES - 1));
    end
  end

endmodule

`default_nettype wire

// ==== up_bus_if.sv ====
`default_nettype none

interface up_bus_if;
  import up_pkg::*;

  logic          sel;    // One-cycle strobe
  logic          wr;
  up_word_addr_t addr;
  up_data_t      wdata;
  up_data_t      rdata;  // Valid with ack
  logic          ack;

  modport master (
    output sel,
    output wr,
    output addr,
    output wdata,
    input  rdata,
    input  ack
  );

  modport slave (
    input  sel,
    input  wr,
    input  addr,
    input  wdata,
    output rdata,
    output ack
  );

endinterface

`default_nettype wire

// ==== up_busif_sva.sv ====
`default_nettype none

module up_busif_sva #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input wire logic             up_clk,
  input wire logic             up_rstn,
  input wire logic             upif_sel,
  input wire logic             upif_wack,
  input wire logic             upif_rack,
  input wire up_pkg::up_data_t upif_rdata
);

  logic        acked;     // Current access already answered
  int unsigned wait_cnt;

  always_ff @(posedge up_clk) begin
    if (!up_rstn || !upif_sel) begin
      acked    <= 1'b0;
      wait_cnt <= 0;
    end else if (upif_wack || upif_rack) begin
      acked <= 1'b1;
    end else if (!acked) begin
      wait_cnt <= wait_cnt + 1;
    end
  end

  a_ack_exclusive: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !(upif_wack && upif_rack)) else $error("wack and rack high together");

  a_ack_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (upif_wack || upif_rack) |=> !(upif_wack || upif_rack))
    else $error("acknowledge longer than one cycle");

  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !upif_rack |-> (upif_rdata == '0)) else $error("rdata not zero outside rack");

  // Bounded by the access timer plus the FSM pipeline
  a_ack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    wait_cnt <= TIMEOUT_CYCLES + 4) else $error("acknowledge came too late");

endmodule

bind up_busif_top up_busif_sva #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_sva (
  .up_clk     (up_clk),
  .up_rstn    (up_rstn),
  .upif_sel   (upif_sel),
  .upif_wack  (upif_wack),
  .upif_rack  (upif_rack),
  .upif_rdata (upif_rdata)
);

`default_nettype wire

// ==== up_busif_top.f ====
up_pkg.sv
up_bus_if.sv
up_access_fsm.sv
up_access_timer.sv
up_common_regs.sv
up_user_regs.sv
up_busif_top.sv
up_busif_sva.sv
tb_up_busif.sv

// ==== up_busif_top.sv ====
`default_nettype none

module up_busif_top #(
  parameter up_pkg::up_data_t  PCORE_VERSION  = 32'h0004_0061,
  parameter up_pkg::up_data_t  PCORE_ID       = 32'd0,
  parameter up_pkg::up_block_t USER_BLOCK     = 10'd1,
  parameter int                USER_NUM_REGS  = 8,
  parameter int                USER_ACK_DELAY = 3,
  parameter int                TIMEOUT_CYCLES = 16
) (
  input  logic                  up_clk,
  input  logic                  up_rstn,
  input  logic                  upif_sel,
  input  logic                  upif_rwn,
  input  up_pkg::up_byte_addr_t upif_addr,
  input  up_pkg::up_data_t      upif_wdata,
  output logic                  upif_wack,
  output logic                  upif_rack,
  output up_pkg::up_data_t      upif_rdata
);

  up_bus_if bus_m ();
  up_bus_if bus_cmn ();
  up_bus_if bus_usr ();

  logic timer_run;
  logic timer_expired;

  // Request fans out to both blocks
  assign bus_cmn.sel   = bus_m.sel;
  assign bus_cmn.wr    = bus_m.wr;
  assign bus_cmn.addr  = bus_m.addr;
  assign bus_cmn.wdata = bus_m.wdata;
  assign bus_usr.sel   = bus_m.sel;
  assign bus_usr.wr    = bus_m.wr;
  assign bus_usr.addr  = bus_m.addr;
  assign bus_usr.wdata = bus_m.wdata;

  // Idle slaves hold zero
  assign bus_m.rdata = bus_cmn.rdata | bus_usr.rdata;
  assign bus_m.ack   = bus_cmn.ack | bus_usr.ack;

  up_access_fsm i_fsm (
    .up_clk        (up_clk),
    .up_rstn       (up_rstn),
    .upif_sel      (upif_sel),
    .upif_rwn      (upif_rwn),
    .upif_addr     (upif_addr),
    .upif_wdata    (upif_wdata),
    .upif_wack     (upif_wack),
    .upif_rack     (upif_rack),
    .upif_rdata    (upif_rdata),
    .bus           (bus_m.master),
    .timer_run     (timer_run),
    .timer_expired (timer_expired)
  );

  up_access_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_timer (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .run     (timer_run),
    .expired (timer_expired)
  );

  up_common_regs #(.PCORE_VERSION(PCORE_VERSION), .PCORE_ID(PCORE_ID)) i_common (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .bus     (bus_cmn.slave)
  );

  up_user_regs #(
    .USER_BLOCK     (USER_BLOCK),
    .USER_NUM_REGS  (USER_NUM_REGS),
    .USER_ACK_DELAY (USER_ACK_DELAY)
  ) i_user (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .bus     (bus_usr.slave)
  );

endmodule

`default_nettype wire

// ==== up_common_regs.sv ====
`default_nettype none

module up_common_regs #(
  parameter up_pkg::up_data_t PCORE_VERSION = 32'h0004_0061,
  parameter up_pkg::up_data_t PCORE_ID      = 32'd0
) (
  input  logic    up_clk,
  input  logic    up_rstn,
  up_bus_if.slave bus
);
  import up_pkg::*;

  logic       hit;
  up_offset_t offset;
  up_data_t   scratch;

  assign hit    = bus.sel && (block_of(bus.addr) == COMMON_BLOCK);
  assign offset = offset_of(bus.addr);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      scratch <= '0;
    end else if (hit && bus.wr && (offset == REG_SCRATCH)) begin
      scratch <= bus.wdata;  // Version and ID are read only
    end
  end

  // Answer one cycle after the strobe
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
    end else begin
      bus.ack <= hit;
      if (hit && !bus.wr) begin
        case (offset)
          REG_VERSION: bus.rdata <= PCORE_VERSION;
          REG_ID:      bus.rdata <= PCORE_ID;
          REG_SCRATCH: bus.rdata <= scratch;
          default:     bus.rdata <= '0;
        endcase
      end else begin
        bus.rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== up_pkg.sv ====
`default_nettype none

package up_pkg;

  localparam int UP_DATA_W      = 32;
  localparam int UP_ADDR_W      = 32;
  localparam int UP_WORD_ADDR_W = 14;
  localparam int UP_BLOCK_W     = 10;
  localparam int UP_OFFSET_W    = 4;

  typedef logic [UP_DATA_W-1:0]      up_data_t;
  typedef logic [UP_ADDR_W-1:0]      up_byte_addr_t;
  typedef logic [UP_WORD_ADDR_W-1:0] up_word_addr_t;  // Byte address bits 15:2
  typedef logic [UP_BLOCK_W-1:0]     up_block_t;
  typedef logic [UP_OFFSET_W-1:0]    up_offset_t;

  // Common block map
  localparam up_block_t  COMMON_BLOCK = 10'd0;
  localparam up_offset_t REG_VERSION  = 4'h0;
  localparam up_offset_t REG_ID       = 4'h1;
  localparam up_offset_t REG_SCRATCH  = 4'h2;

  // Returned on a read that nobody answered
  localparam up_data_t TIMEOUT_DATA = 32'hdead_dead;

  // Upper bits of the word address pick the block
  function automatic up_block_t block_of(up_word_addr_t addr);
    return addr[UP_WORD_ADDR_W-1:UP_OFFSET_W];
  endfunction

  function automatic up_offset_t offset_of(up_word_addr_t addr);
    return addr[UP_OFFSET_W-1:0];
  endfunction

endpackage

`default_nettype wire

// ==== up_user_regs.sv ====
`default_nettype none

module up_user_regs #(
  parameter up_pkg::up_block_t USER_BLOCK     = 10'd1,
  parameter int                USER_NUM_REGS  = 8,
  parameter int                USER_ACK_DELAY = 3
) (
  input  logic    up_clk,
  input  logic    up_rstn,
  up_bus_if.slave bus
);
  import up_pkg::*;

  localparam int IDX_W = (USER_NUM_REGS > 1) ? $clog2(USER_NUM_REGS) : 1;

  logic                      hit;
  logic [USER_ACK_DELAY-1:0] ack_sr;
  up_offset_t                offset;
  logic [IDX_W-1:0]          idx;
  logic                      in_range;
  up_data_t                  regs [USER_NUM_REGS];

  assign hit      = bus.sel && (block_of(bus.addr) == USER_BLOCK);
  assign offset   = offset_of(bus.addr);
  assign idx      = offset[IDX_W-1:0];
  assign in_range = (int'(offset) < USER_NUM_REGS);

  // Address and data are still held by the master when the ack leaves
  assign bus.ack   = ack_sr[USER_ACK_DELAY-1];
  assign bus.rdata = (bus.ack && !bus.wr && in_range) ? regs[idx] : '0;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ack_sr <= '0;
    end else begin
      ack_sr[0] <= hit;
      for (int i = 1; i < USER_ACK_DELAY; i++) begin
        ack_sr[i] <= ack_sr[i-1];
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      for (int i = 0; i < USER_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.ack && bus.wr && in_range) begin
      regs[idx] <= bus.wdata;  // Offsets past the bank are dropped
    end
  end

endmodule

`default_nettype wire
